//--- hdl/dcache_pkg.sv
package dcache_pkg;

    localparam int XLEN         = 32;
    localparam int BLOCK_BITS   = 64;
    localparam int BLOCK_OFFSET = 3;
    localparam int MEM_TAG_BITS = 4;
    localparam int LINE_BITS    = XLEN - BLOCK_OFFSET;  // line address width

    typedef enum logic [1:0] {READY, WAIT_MSHR, WAIT} dc_state_e;
    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_e;
    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_e;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_e;

    typedef struct packed {
        logic            valid;
        mem_op_e         op;
        mem_size_e       size;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } dcache_resp_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [LINE_BITS-1:0]  line;
        logic [BLOCK_BITS-1:0] block;
    } cache_line_t;

    typedef struct packed {
        logic                  valid;
        logic [LINE_BITS-1:0]  line;
        logic [BLOCK_BITS-1:0] data;
    } refill_t;

    typedef struct packed {
        bus_cmd_e              cmd;
        logic [XLEN-1:0]       addr;
        logic [BLOCK_BITS-1:0] data;
    } mem_cmd_t;

    // write the store data of req into its byte lanes of a line
    function automatic logic [BLOCK_BITS-1:0] merge_store(input logic [BLOCK_BITS-1:0] block,
                                                          input dcache_req_t req);
        logic [BLOCK_BITS-1:0] merged;
        merged = block;
        case (req.size)
            BYTE:    merged[req.addr[2:0]*8 +: 8]   = req.wdata[7:0];
            HALF:    merged[req.addr[2:1]*16 +: 16] = req.wdata[15:0];
            default: merged[req.addr[2]*32 +: 32]   = req.wdata;
        endcase
        return merged;
    endfunction

endpackage

//--- hdl/main_cache.sv
`timescale 1ns/100ps

module main_cache #(
    parameter int N_CL = 8
) (
    input  logic                              clock,
    input  logic                              reset,
    input  dcache_pkg::dcache_req_t           access,
    input  logic                              store_en,
    input  dcache_pkg::refill_t               refill,
    output logic                              hit,
    output logic [dcache_pkg::BLOCK_BITS-1:0] hit_block,
    output dcache_pkg::cache_line_t           evict
);

    localparam int IDX_BITS = $clog2(N_CL);
    localparam int TAG_BITS = dcache_pkg::LINE_BITS - IDX_BITS;

    logic [N_CL-1:0]                   valid;
    logic [N_CL-1:0]                   dirty;
    logic [TAG_BITS-1:0]               tags   [N_CL];
    logic [dcache_pkg::BLOCK_BITS-1:0] blocks [N_CL];

    logic [IDX_BITS-1:0] idx, ridx;
    logic [TAG_BITS-1:0] tag, rtag;
    logic                fill_store;

    assign idx  = access.addr[dcache_pkg::BLOCK_OFFSET +: IDX_BITS];
    assign tag  = access.addr[dcache_pkg::XLEN-1 -: TAG_BITS];
    assign ridx = refill.line[IDX_BITS-1:0];
    assign rtag = refill.line[dcache_pkg::LINE_BITS-1 -: TAG_BITS];

    assign hit       = access.valid & valid[idx] & (tags[idx] == tag);
    assign hit_block = blocks[idx];

    // store miss completing on this refill
    assign fill_store = store_en &
        (refill.line == access.addr[dcache_pkg::XLEN-1:dcache_pkg::BLOCK_OFFSET]);

    // the line being displaced goes to the victim cache
    always_comb begin
        evict.valid = refill.valid & valid[ridx];
        evict.dirty = dirty[ridx];
        evict.line  = {tags[ridx], ridx};
        evict.block = blocks[ridx];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (refill.valid) begin
            valid[ridx] <= 1'b1;
            dirty[ridx] <= fill_store;  // clean unless a store rides along
        end else if (hit & store_en) begin
            dirty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (refill.valid) begin
            tags[ridx]   <= rtag;
            blocks[ridx] <= fill_store ? dcache_pkg::merge_store(refill.data, access)
                                       : refill.data;
        end else if (hit & store_en) begin
            blocks[idx] <= dcache_pkg::merge_store(blocks[idx], access);
        end
    end

endmodule

//--- hdl/victim_cache.sv
`timescale 1ns/100ps

module victim_cache #(
    parameter int N_VC = 4
) (
    input  logic                              clock,
    input  logic                              reset,
    input  dcache_pkg::dcache_req_t           access,
    input  logic                              store_en,
    input  dcache_pkg::cache_line_t           evict_in,
    output logic                              hit,
    output logic [dcache_pkg::BLOCK_BITS-1:0] hit_block,
    output dcache_pkg::cache_line_t           writeback
);

    localparam int IDX_BITS = $clog2(N_VC);

    logic [N_VC-1:0]                   valid;
    logic [N_VC-1:0]                   dirty;
    logic [IDX_BITS-1:0]               lru    [N_VC];  // higher means more recently used
    logic [dcache_pkg::LINE_BITS-1:0]  lines  [N_VC];
    logic [dcache_pkg::BLOCK_BITS-1:0] blocks [N_VC];

    logic [dcache_pkg::LINE_BITS-1:0] acc_line;
    logic [N_VC-1:0]                  match;
    logic [IDX_BITS-1:0]              hit_idx;
    logic [IDX_BITS-1:0]              sel;   // slot for an incoming line
    logic [IDX_BITS-1:0]              low;

    assign acc_line = access.addr[dcache_pkg::XLEN-1:dcache_pkg::BLOCK_OFFSET];

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < N_VC; i++) begin
            match[i] = access.valid & valid[i] & (lines[i] == acc_line);
            if (match[i]) hit_idx = IDX_BITS'(i);
        end
        hit       = |match;
        hit_block = blocks[hit_idx];
    end

    // lowest count first, then any free slot overrides it
    always_comb begin
        sel = '0;
        low = lru[0];
        for (int i = 1; i < N_VC; i++) begin
            if (lru[i] < low) begin
                low = lru[i];
                sel = IDX_BITS'(i);
            end
        end
        for (int i = N_VC - 1; i >= 0; i--) begin
            if (!valid[i]) sel = IDX_BITS'(i);
        end
    end

    // only dirty lines go back to memory
    always_comb begin
        writeback.valid = evict_in.valid & valid[sel] & dirty[sel];
        writeback.dirty = dirty[sel];
        writeback.line  = lines[sel];
        writeback.block = blocks[sel];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            for (int i = 0; i < N_VC; i++) lru[i] <= '0;
        end else if (evict_in.valid) begin
            valid[sel] <= 1'b1;
            dirty[sel] <= evict_in.dirty;
            lru[sel]   <= '0;
        end else if (hit) begin
            for (int i = 0; i < N_VC; i++) begin
                if (IDX_BITS'(i) == hit_idx) lru[i] <= '1;
                else if (lru[i] != '0)       lru[i] <= lru[i] - 1'b1;
            end
            if (store_en) dirty[hit_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (evict_in.valid) begin
            lines[sel]  <= evict_in.line;
            blocks[sel] <= evict_in.block;
        end else if (hit & store_en) begin
            blocks[hit_idx] <= dcache_pkg::merge_store(blocks[hit_idx], access);
        end
    end

    // a line lives in one place only, main cache or one victim slot
    a_single_match: assert property (@(posedge clock) disable iff (reset) $onehot0(match))
        else $error("victim_cache: line present in more than one slot");

endmodule

//--- hdl/mshr_table.sv
`timescale 1ns/100ps

module mshr_table #(
    parameter int N_MSHR = 4
) (
    input  logic                                clock,
    input  logic                                reset,
    input  dcache_pkg::dcache_req_t             access,
    input  logic                                alloc,
    input  dcache_pkg::cache_line_t             writeback,
    input  logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input  logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_tag,
    input  logic [dcache_pkg::BLOCK_BITS-1:0]   mem_data,
    output dcache_pkg::mem_cmd_t                mem_cmd,
    output dcache_pkg::refill_t                 refill,
    output logic                                full,
    output logic                                wb_conflict
);

    localparam int IDX_BITS = $clog2(N_MSHR);

    logic [N_MSHR-1:0]                   valid;
    dcache_pkg::mem_op_e                 op    [N_MSHR];
    logic [dcache_pkg::LINE_BITS-1:0]    lines [N_MSHR];
    logic [dcache_pkg::BLOCK_BITS-1:0]   data  [N_MSHR];
    logic [dcache_pkg::MEM_TAG_BITS-1:0] tags  [N_MSHR];  // zero until memory accepts

    logic [dcache_pkg::LINE_BITS-1:0] acc_line;
    logic                issue;
    logic [IDX_BITS-1:0] issue_idx;
    logic                accepted;
    logic [N_MSHR-1:0]   ret_match;
    logic [IDX_BITS-1:0] ret_idx;
    logic [IDX_BITS-1:0] free_idx;
    logic [IDX_BITS:0]   free_cnt;

    assign acc_line = access.addr[dcache_pkg::XLEN-1:dcache_pkg::BLOCK_OFFSET];

    always_comb begin
        issue       = 1'b0;
        issue_idx   = '0;
        ret_idx     = '0;
        free_idx    = '0;
        free_cnt    = '0;
        wb_conflict = 1'b0;
        for (int i = N_MSHR - 1; i >= 0; i--) begin
            if (valid[i] & (op[i] == dcache_pkg::MEM_READ) & (tags[i] == '0)) begin
                issue     = 1'b1;
                issue_idx = IDX_BITS'(i);
            end
        end
        for (int i = N_MSHR - 1; i >= 0; i--) begin  // write-backs win over the refill
            if (valid[i] & (op[i] == dcache_pkg::MEM_WRITE)) begin
                issue     = 1'b1;
                issue_idx = IDX_BITS'(i);
            end
        end
        for (int i = 0; i < N_MSHR; i++) begin
            ret_match[i] = valid[i] & (op[i] == dcache_pkg::MEM_READ) &
                           (mem_tag != '0) & (tags[i] == mem_tag);
            if (ret_match[i]) ret_idx = IDX_BITS'(i);
            if (!valid[i]) begin
                free_idx = IDX_BITS'(i);
                free_cnt = free_cnt + 1'b1;
            end
            if (valid[i] & (op[i] == dcache_pkg::MEM_WRITE) & (lines[i] == acc_line))
                wb_conflict = access.valid;
        end
    end

    assign accepted = issue & (mem_response != '0);
    assign full     = (free_cnt < 2);  // one slot stays back for the eviction a refill may cause

    always_comb begin
        mem_cmd.cmd  = !issue ? dcache_pkg::BUS_NONE :
                       (op[issue_idx] == dcache_pkg::MEM_READ) ? dcache_pkg::BUS_LOAD
                                                               : dcache_pkg::BUS_STORE;
        mem_cmd.addr = {lines[issue_idx], {dcache_pkg::BLOCK_OFFSET{1'b0}}};
        mem_cmd.data = data[issue_idx];
        refill.valid = |ret_match;
        refill.line  = lines[ret_idx];
        refill.data  = mem_data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (|ret_match) valid[ret_idx] <= 1'b0;
            if (accepted & (op[issue_idx] == dcache_pkg::MEM_WRITE)) valid[issue_idx] <= 1'b0;
            if (alloc | writeback.valid) valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accepted) tags[issue_idx] <= mem_response;
        if (alloc) begin
            op[free_idx]    <= dcache_pkg::MEM_READ;
            lines[free_idx] <= acc_line;
            tags[free_idx]  <= '0;
        end else if (writeback.valid) begin
            op[free_idx]    <= dcache_pkg::MEM_WRITE;
            lines[free_idx] <= writeback.line;
            data[free_idx]  <= writeback.block;
            tags[free_idx]  <= '0;
        end
    end

    a_tag_match: assert property (@(posedge clock) disable iff (reset)
        (mem_tag != '0) |-> $onehot(ret_match))
        else $error("mshr_table: returning tag %0d matches no single read entry", mem_tag);

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                                   clock,
    input  logic                                   reset,
    input  dcache_pkg::dcache_req_t                req,
    input  logic                                   main_hit,
    input  logic                                   victim_hit,
    input  logic [dcache_pkg::BLOCK_BITS-1:0]      main_block,
    input  logic [dcache_pkg::BLOCK_BITS-1:0]      victim_block,
    input  logic                                   full,
    input  logic                                   wb_conflict,
    input  dcache_pkg::refill_t                    refill,
    output dcache_pkg::dcache_req_t                access,
    output logic                                   store_en,
    output logic                                   alloc,
    output dcache_pkg::dcache_resp_t               resp,
    output logic                                   stall
);

    dcache_pkg::dc_state_e   state, next_state;
    dcache_pkg::dcache_req_t wait_req;  // request parked during a miss
    logic                    hit;
    logic                    done;
    logic [dcache_pkg::BLOCK_BITS-1:0] sel_block;
    logic [dcache_pkg::XLEN-1:0]       word;
    logic [dcache_pkg::XLEN-1:0]       load_data;
    logic                              resp_valid;
    logic [dcache_pkg::XLEN-1:0]       resp_data;

    assign access = (state == dcache_pkg::READY) ? req : wait_req;
    assign hit    = main_hit | victim_hit;
    assign stall  = (state != dcache_pkg::READY);

    // the refill that ends a miss carries the waiting line
    assign done = (state == dcache_pkg::WAIT) & refill.valid &
                  (refill.line == access.addr[dcache_pkg::XLEN-1:dcache_pkg::BLOCK_OFFSET]);

    // a waiting store is folded into the refill as it installs
    assign store_en = access.valid & (access.op == dcache_pkg::MEM_WRITE) &
                      ((state == dcache_pkg::READY) | done);

    always_comb begin
        next_state = state;
        alloc      = 1'b0;
        if (((state == dcache_pkg::READY) & req.valid & ~hit) |
            (state == dcache_pkg::WAIT_MSHR)) begin
            if (full | wb_conflict) begin
                next_state = dcache_pkg::WAIT_MSHR;  // no room yet, or line still leaving
            end else begin
                alloc      = 1'b1;
                next_state = dcache_pkg::WAIT;
            end
        end else if (done) begin
            next_state = dcache_pkg::READY;
        end
    end

    // pick the line, then the word, then the lane
    always_comb begin
        sel_block = done ? refill.data : (main_hit ? main_block : victim_block);
        word      = sel_block[access.addr[2]*32 +: 32];
        case (access.size)
            dcache_pkg::BYTE: load_data = {24'b0, word[access.addr[1:0]*8 +: 8]};
            dcache_pkg::HALF: load_data = {16'b0, word[access.addr[1]*16 +: 16]};
            default:          load_data = word;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= dcache_pkg::READY;
            resp_valid <= 1'b0;
        end else begin
            state      <= next_state;
            resp_valid <= ((state == dcache_pkg::READY) & req.valid & hit) | done;
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= load_data;
        if (state == dcache_pkg::READY) wait_req <= req;
    end

    assign resp = '{valid: resp_valid, rdata: resp_data};

    // the only read in flight is the one for the waiting line
    a_refill_waited: assert property (@(posedge clock) disable iff (reset) refill.valid |-> done)
        else $error("dcache_ctrl: refill returned for a line no miss is waiting on");

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
    parameter int N_CL   = 8,
    parameter int N_VC   = 4,
    parameter int N_MSHR = 4
) (
    input  logic                                clock,
    input  logic                                reset,
    input  dcache_pkg::dcache_req_t             req,
    output dcache_pkg::dcache_resp_t            resp,
    output logic                                stall,
    output dcache_pkg::mem_cmd_t                mem_cmd,
    input  logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input  logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_tag,
    input  logic [dcache_pkg::BLOCK_BITS-1:0]   mem_data
);

    dcache_pkg::dcache_req_t           access;
    logic                              store_en;
    logic                              alloc;
    logic                              main_hit, victim_hit;
    logic [dcache_pkg::BLOCK_BITS-1:0] main_block, victim_block;
    logic                              full, wb_conflict;
    dcache_pkg::refill_t               refill;
    dcache_pkg::cache_line_t           evict;      // main cache to victim cache
    dcache_pkg::cache_line_t           writeback;  // victim cache to miss table

    dcache_ctrl u_dcache_ctrl (
        .clock, .reset, .req,
        .main_hit, .victim_hit, .main_block, .victim_block,
        .full, .wb_conflict, .refill,
        .access, .store_en, .alloc, .resp, .stall
    );

    main_cache #(.N_CL(N_CL)) u_main_cache (
        .clock, .reset, .access, .store_en, .refill,
        .hit(main_hit), .hit_block(main_block), .evict
    );

    victim_cache #(.N_VC(N_VC)) u_victim_cache (
        .clock, .reset, .access, .store_en, .evict_in(evict),
        .hit(victim_hit), .hit_block(victim_block), .writeback
    );

    mshr_table #(.N_MSHR(N_MSHR)) u_mshr_table (
        .clock, .reset, .access, .alloc, .writeback,
        .mem_response, .mem_tag, .mem_data,
        .mem_cmd, .refill, .full, .wb_conflict
    );

endmodule

//--- tests/mem_model.sv
`timescale 1ns/100ps

module mem_model #(
    parameter int          MEM_LINES = 512,
    parameter logic [31:0] PATTERN   = 32'h5a5a0000
) (
    input  logic                                clock,
    input  logic                                reset,
    input  dcache_pkg::mem_cmd_t                mem_cmd,
    output logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_response,
    output logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_tag,
    output logic [dcache_pkg::BLOCK_BITS-1:0]   mem_data,
    output int                                  load_count,
    output int                                  store_count
);

    localparam int IDX_BITS = $clog2(MEM_LINES);

    logic [dcache_pkg::BLOCK_BITS-1:0]   lines [MEM_LINES];
    integer                              seed       = 32'h630aefee;
    logic                                grant      = 1'b0;  // accept the command offered now
    logic [dcache_pkg::MEM_TAG_BITS-1:0] next_tag   = dcache_pkg::MEM_TAG_BITS'(1);
    logic                                pend_valid = 1'b0;
    logic [dcache_pkg::MEM_TAG_BITS-1:0] pend_tag   = '0;
    logic [dcache_pkg::BLOCK_BITS-1:0]   pend_data  = '0;
    int                                  pend_wait  = 0;
    logic [dcache_pkg::MEM_TAG_BITS-1:0] ret_tag    = '0;
    logic [dcache_pkg::BLOCK_BITS-1:0]   ret_data   = '0;
    int                                  loads      = 0;
    int                                  stores     = 0;
    logic [IDX_BITS-1:0]                 idx;

    // each 32-bit word holds its own byte address xor the pattern
    initial begin
        for (int i = 0; i < MEM_LINES; i++) begin
            lines[i] = {32'(i * 8 + 4) ^ PATTERN, 32'(i * 8) ^ PATTERN};
        end
    end

    assign idx          = mem_cmd.addr[dcache_pkg::BLOCK_OFFSET +: IDX_BITS];
    assign mem_response = (grant && mem_cmd.cmd != dcache_pkg::BUS_NONE) ? next_tag : '0;
    assign mem_tag      = ret_tag;
    assign mem_data     = ret_data;
    assign load_count   = loads;
    assign store_count  = stores;

    always @(posedge clock) begin
        if (reset) begin
            grant      <= 1'b0;
            next_tag   <= dcache_pkg::MEM_TAG_BITS'(1);
            pend_valid <= 1'b0;
            ret_tag    <= '0;
        end else begin
            grant   <= ($random(seed) & 3) != 0;  // about three cycles in four
            ret_tag <= '0;
            if (pend_valid) begin
                if (pend_wait == 0) begin
                    ret_tag    <= pend_tag;
                    ret_data   <= pend_data;
                    pend_valid <= 1'b0;
                end else begin
                    pend_wait <= pend_wait - 1;
                end
            end
            if (mem_response != '0) begin
                // tag zero means refused
                next_tag <= (next_tag == '1) ? dcache_pkg::MEM_TAG_BITS'(1)
                                             : next_tag + 1'b1;
                if (mem_cmd.cmd == dcache_pkg::BUS_STORE) begin
                    lines[idx] <= mem_cmd.data;
                    stores     <= stores + 1;
                end else begin
                    pend_valid <= 1'b1;
                    pend_tag   <= mem_response;
                    pend_data  <= lines[idx];
                    pend_wait  <= 1 + ($unsigned($random(seed)) % 5);  // data after 2 to 6 cycles
                    loads      <= loads + 1;
                end
            end
        end
    end

endmodule

//--- tests/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int CYCLES_PER_REQ = 200;
    localparam int MAX_REQS       = 64;

    logic                                clock  = 1'b0;
    logic                                reset  = 1'b1;
    logic                                loaded = 1'b0;
    dcache_pkg::dcache_req_t             req;
    dcache_pkg::dcache_resp_t            resp;
    logic                                stall;
    dcache_pkg::mem_cmd_t                mem_cmd;
    logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_response, mem_tag;
    logic [dcache_pkg::BLOCK_BITS-1:0]   mem_data;
    int                                  load_count, store_count;

    // requests and expected results from the data file
    dcache_pkg::dcache_req_t reqs       [MAX_REQS];
    logic [31:0]             exp_rdata  [MAX_REQS];
    int                      exp_loads  [MAX_REQS];
    int                      exp_stores [MAX_REQS];
    int                      n_req = 0;

    dcache_top #(.N_CL(8), .N_VC(4), .N_MSHR(4)) u_dcache_top (
        .clock, .reset, .req, .resp, .stall,
        .mem_cmd, .mem_response, .mem_tag, .mem_data
    );

    mem_model u_mem_model (
        .clock, .reset, .mem_cmd, .mem_response, .mem_tag, .mem_data,
        .load_count, .store_count
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic read_requests();
        int          fd;
        string       text;
        int          op, size, loads, stores, n;
        logic [31:0] addr, wdata, rdata;
        fd = $fopen("tests/dcache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the request file tests/dcache_input.txt");
            stop_run();
        end else begin
            while ($fgets(text, fd) > 0) begin
                n = 0;
                if (text.len() > 1 && text[0] != "#" && n_req < MAX_REQS)
                    n = $sscanf(text, "%h %h %h %h %h %d %d",
                                op, size, addr, wdata, rdata, loads, stores);
                if (n == 7) begin
                    reqs[n_req].valid  = 1'b1;
                    reqs[n_req].op     = dcache_pkg::mem_op_e'(op);
                    reqs[n_req].size   = dcache_pkg::mem_size_e'(size);
                    reqs[n_req].addr   = addr;
                    reqs[n_req].wdata  = wdata;
                    exp_rdata[n_req]   = rdata;
                    exp_loads[n_req]   = loads;
                    exp_stores[n_req]  = stores;
                    n_req++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one request, then wait for its response at the falling edge
    task automatic run_request(input int i);
        logic expect_hit;
        expect_hit = (exp_loads[i] == ((i == 0) ? 0 : exp_loads[i-1]));  // no new refill
        @(posedge clock);
        req <= reqs[i];
        @(posedge clock);
        req.valid <= 1'b0;
        @(negedge clock);
        if (expect_hit) begin
            check_value("resp.valid", resp.valid, 1'b1);
        end else begin
            check_value("stall", stall, 1'b1);
            while (!resp.valid) @(negedge clock);
        end
        check_value("stall", stall, 1'b0);
        if (reqs[i].op == dcache_pkg::MEM_READ)
            check_value("resp.rdata", resp.rdata, exp_rdata[i]);
        check_value("memory load count", load_count, exp_loads[i]);
        check_value("memory store count", store_count, exp_stores[i]);
    endtask

    initial begin
        req = '0;
        read_requests();
        loaded = 1'b1;
        if (n_req == 0) begin
            $display("the request file holds no requests");
            stop_run();
        end else begin
            repeat (RESET_CYCLES) @(posedge clock);
            reset <= 1'b0;
            @(negedge clock);
            check_value("stall", stall, 1'b0);  // idle after reset
            check_value("resp.valid", resp.valid, 1'b0);
            check_value("mem_cmd.cmd", mem_cmd.cmd, dcache_pkg::BUS_NONE);
            for (int i = 0; i < n_req; i++) run_request(i);
            $display("%0d requests answered as expected", n_req);
            $display("TB PASSED");
            $finish;
        end
    end

    // watchdog sized from the number of requests
    initial begin
        wait (loaded);
        #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_REQ * n_req));
        $display("timeout: the cache did not answer all %0d requests in time", n_req);
        stop_run();
    end

endmodule

//--- src.f
hdl/dcache_pkg.sv
hdl/main_cache.sv
hdl/victim_cache.sv
hdl/mshr_table.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/main_cache.sv
  - hdl/victim_cache.sv
  - hdl/mshr_table.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/dcache_tb.sv

//--- tests/dcache_input.txt
# op (0 load, 1 store)  size (0 byte, 1 half, 2 word)  addr  wdata  rdata, all hex
# then memory loads and stores seen by the model when the response arrives, decimal
0 2 00000010 00000000 5a5a0010 1 0
0 2 00000014 00000000 5a5a0014 1 0
1 0 00000021 000000ab 00000000 2 0
1 1 00000022 0000cdef 00000000 2 0
1 2 00000024 12345678 00000000 2 0
0 2 00000020 00000000 cdefab20 2 0
0 2 00000024 00000000 12345678 2 0
0 0 00000023 00000000 000000cd 2 0
0 1 00000020 00000000 0000ab20 2 0
0 2 00000008 00000000 5a5a0008 3 0
0 2 0000004c 00000000 5a5a004c 4 0
0 2 00000008 00000000 5a5a0008 4 0
0 2 00000048 00000000 5a5a0048 4 0
1 2 00000040 11111111 00000000 5 0
1 2 00000080 22222222 00000000 6 0
0 2 000000c0 00000000 5a5a00c0 7 0
0 2 00000100 00000000 5a5a0100 8 0
0 2 00000140 00000000 5a5a0140 9 0
0 2 00000180 00000000 5a5a0180 10 1
0 2 00000040 00000000 11111111 11 1
0 2 00000044 00000000 5a5a0044 11 1
0 2 00000080 00000000 22222222 11 1
0 0 00000086 00000000 0000005a 11 1
